/* axi_master.sv */
`include "core_defs.svh"

module axi_master (
    input  logic               clk,
    input  logic               rst_n_i,
    mem_port_if.responder      port,
    output logic [`ADDR_W-1:0] m_axi_araddr_o,
    output logic               m_axi_arvalid_o,
    input  logic               m_axi_arready_i,
    input  logic [`DATA_W-1:0] m_axi_rdata_i,
    input  logic               m_axi_rvalid_i,
    output logic               m_axi_rready_o,
    output logic [`ADDR_W-1:0] m_axi_awaddr_o,
    output logic               m_axi_awvalid_o,
    input  logic               m_axi_awready_i,
    output logic [`DATA_W-1:0] m_axi_wdata_o,
    output logic [`STRB_W-1:0] m_axi_wstrb_o,
    output logic               m_axi_wvalid_o,
    input  logic               m_axi_wready_i,
    input  logic               m_axi_bvalid_i,
    output logic               m_axi_bready_o
);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_AR   = 3'd1;
    localparam logic [2:0] S_R    = 3'd2;
    localparam logic [2:0] S_WR   = 3'd3;
    localparam logic [2:0] S_B    = 3'd4;
    localparam logic [2:0] S_DONE = 3'd5;

    logic [2:0]         state;
    logic [`ADDR_W-1:0] addr_q;
    logic [`DATA_W-1:0] wdata_q;
    logic [`STRB_W-1:0] wstrb_q;
    logic [`DATA_W-1:0] rdata_q;
    logic               aw_left;
    logic               w_left;

    // AW and W may be accepted in either order
    assign aw_left = m_axi_awvalid_o && !m_axi_awready_i;
    assign w_left  = m_axi_wvalid_o && !m_axi_wready_i;

    assign m_axi_araddr_o = addr_q;
    assign m_axi_awaddr_o = addr_q;
    assign m_axi_wdata_o  = wdata_q;
    assign m_axi_wstrb_o  = wstrb_q;
    assign port.done      = (state == S_DONE);
    assign port.rdata     = rdata_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state           <= S_IDLE;
            m_axi_arvalid_o <= 1'b0;
            m_axi_rready_o  <= 1'b0;
            m_axi_awvalid_o <= 1'b0;
            m_axi_wvalid_o  <= 1'b0;
            m_axi_bready_o  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (port.req && port.we) begin
                        m_axi_awvalid_o <= 1'b1;
                        m_axi_wvalid_o  <= 1'b1;
                        state           <= S_WR;
                    end else if (port.req) begin
                        m_axi_arvalid_o <= 1'b1;
                        state           <= S_AR;
                    end
                end
                S_AR: begin
                    if (m_axi_arready_i) begin
                        m_axi_arvalid_o <= 1'b0;
                        m_axi_rready_o  <= 1'b1;
                        state           <= S_R;
                    end
                end
                S_R: begin
                    if (m_axi_rvalid_i) begin
                        m_axi_rready_o <= 1'b0;
                        state          <= S_DONE;
                    end
                end
                S_WR: begin
                    if (m_axi_awready_i) begin
                        m_axi_awvalid_o <= 1'b0;
                    end
                    if (m_axi_wready_i) begin
                        m_axi_wvalid_o <= 1'b0;
                    end
                    if (!aw_left && !w_left) begin
                        m_axi_bready_o <= 1'b1;
                        state          <= S_B;
                    end
                end
                S_B: begin
                    if (m_axi_bvalid_i) begin
                        m_axi_bready_o <= 1'b0;
                        state          <= S_DONE;
                    end
                end
                default: begin
                    // Done lasts one cycle, the old request is still up here
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && port.req) begin
            addr_q  <= port.addr;
            wdata_q <= port.wdata;
            wstrb_q <= port.wstrb;
        end
        if (state == S_R && m_axi_rvalid_i) begin
            rdata_q <= m_axi_rdata_i;
        end
    end

endmodule

/* bus_pkg.sv */
package bus_pkg;

    // Width of a data access
    // The low two address bits pick the byte lane inside the word
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

endpackage

/* cache_pkg.sv */
`include "core_defs.svh"

package cache_pkg;

    // Fetch address as seen by the cache lookup
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-1:0] offset;
        logic [1:0]           byte_sel;
    } cache_addr_fields_t;

    // Same word, either as a bus address or split into lookup fields
    typedef union packed {
        logic [`ADDR_W-1:0] raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

    // One line, word 0 in the low bits
    typedef logic [`LINE_WORDS-1:0][`DATA_W-1:0] line_t;

endpackage

/* compile.f */
+incdir+.
bus_pkg.sv
cache_pkg.sv
mem_port_if.sv
icache.sv
data_port.sv
mem_arbiter.sv
axi_master.sv
cpu_mem_top.sv
tb_cpu_mem.sv

/* core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// Instruction cache geometry
`define LINE_WORDS 4
`define OFFSET_W 2
`define ICACHE_SETS 16
`define INDEX_W 4

// Address split is tag, index, word offset, byte
`define TAG_W 24

`endif

/* cpu_mem_top.sv */
`include "core_defs.svh"

module cpu_mem_top import bus_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    // Instruction fetch
    input  logic               fetch_req_i,
    input  logic [`ADDR_W-1:0] fetch_addr_i,
    output logic               fetch_valid_o,
    output logic [`DATA_W-1:0] fetch_data_o,
    // Data load/store
    input  logic               data_req_i,
    input  logic               data_we_i,
    input  logic [`ADDR_W-1:0] data_addr_i,
    input  access_size_e       data_size_i,
    input  logic [`DATA_W-1:0] data_wdata_i,
    output logic               data_valid_o,
    output logic [`DATA_W-1:0] data_rdata_o,
    // AXI master
    output logic [`ADDR_W-1:0] m_axi_araddr_o,
    output logic               m_axi_arvalid_o,
    input  logic               m_axi_arready_i,
    input  logic [`DATA_W-1:0] m_axi_rdata_i,
    input  logic               m_axi_rvalid_i,
    output logic               m_axi_rready_o,
    output logic [`ADDR_W-1:0] m_axi_awaddr_o,
    output logic               m_axi_awvalid_o,
    input  logic               m_axi_awready_i,
    output logic [`DATA_W-1:0] m_axi_wdata_o,
    output logic [`STRB_W-1:0] m_axi_wstrb_o,
    output logic               m_axi_wvalid_o,
    input  logic               m_axi_wready_i,
    input  logic               m_axi_bvalid_i,
    output logic               m_axi_bready_o
);

    mem_port_if if_ifetch ();
    mem_port_if if_data ();
    mem_port_if if_bus ();

    icache u_icache (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_valid_o(fetch_valid_o),
        .fetch_data_o (fetch_data_o),
        .mem          (if_ifetch.requester)
    );

    data_port u_data_port (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .data_req_i  (data_req_i),
        .data_we_i   (data_we_i),
        .data_addr_i (data_addr_i),
        .data_size_i (data_size_i),
        .data_wdata_i(data_wdata_i),
        .data_valid_o(data_valid_o),
        .data_rdata_o(data_rdata_o),
        .mem         (if_data.requester)
    );

    mem_arbiter u_mem_arbiter (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .ifetch (if_ifetch.responder),
        .data   (if_data.responder),
        .bus    (if_bus.requester)
    );

    axi_master u_axi_master (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .port           (if_bus.responder),
        .m_axi_araddr_o (m_axi_araddr_o),
        .m_axi_arvalid_o(m_axi_arvalid_o),
        .m_axi_arready_i(m_axi_arready_i),
        .m_axi_rdata_i  (m_axi_rdata_i),
        .m_axi_rvalid_i (m_axi_rvalid_i),
        .m_axi_rready_o (m_axi_rready_o),
        .m_axi_awaddr_o (m_axi_awaddr_o),
        .m_axi_awvalid_o(m_axi_awvalid_o),
        .m_axi_awready_i(m_axi_awready_i),
        .m_axi_wdata_o  (m_axi_wdata_o),
        .m_axi_wstrb_o  (m_axi_wstrb_o),
        .m_axi_wvalid_o (m_axi_wvalid_o),
        .m_axi_wready_i (m_axi_wready_i),
        .m_axi_bvalid_i (m_axi_bvalid_i),
        .m_axi_bready_o (m_axi_bready_o)
    );

endmodule

/* data_port.sv */
`include "core_defs.svh"

module data_port import bus_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               data_req_i,
    input  logic               data_we_i,
    input  logic [`ADDR_W-1:0] data_addr_i,
    input  access_size_e       data_size_i,
    input  logic [`DATA_W-1:0] data_wdata_i,
    output logic               data_valid_o,
    output logic [`DATA_W-1:0] data_rdata_o,
    mem_port_if.requester      mem
);

    logic [`STRB_W-1:0] strb;
    logic [`DATA_W-1:0] lane_wdata;
    logic [1:0]         lane_q;
    access_size_e       size_q;
    logic [`DATA_W-1:0] shifted;
    logic [`DATA_W-1:0] load_data;

    // Byte lanes and replicated store data
    always_comb begin
        case (data_size_i)
            SIZE_BYTE: begin
                strb       = 4'b0001 << data_addr_i[1:0];
                lane_wdata = {4{data_wdata_i[7:0]}};
            end
            SIZE_HALF: begin
                strb       = 4'b0011 << {data_addr_i[1], 1'b0};
                lane_wdata = {2{data_wdata_i[15:0]}};
            end
            default: begin
                strb       = 4'b1111;
                lane_wdata = data_wdata_i;
            end
        endcase
    end

    // Load lane moved down to bit 0, zero-extended
    assign shifted = mem.rdata >> {lane_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: load_data = {{(`DATA_W-8){1'b0}}, shifted[7:0]};
            SIZE_HALF: load_data = {{(`DATA_W-16){1'b0}}, shifted[15:0]};
            default:   load_data = mem.rdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem.req      <= 1'b0;
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= 1'b0;
            if (!mem.req) begin
                mem.req <= data_req_i;
            end else if (mem.done) begin
                mem.req      <= 1'b0;
                data_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem.req && data_req_i) begin
            mem.we    <= data_we_i;
            mem.addr  <= {data_addr_i[`ADDR_W-1:2], 2'b00};
            mem.wdata <= lane_wdata;
            mem.wstrb <= strb;
            lane_q    <= data_addr_i[1:0];
            size_q    <= data_size_i;
        end
        if (mem.req && mem.done) begin
            data_rdata_o <= mem.we ? '0 : load_data;
        end
    end

endmodule

/* icache.sv */
`include "core_defs.svh"

module icache import cache_pkg::*; (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               fetch_req_i,
    input  logic [`ADDR_W-1:0] fetch_addr_i,
    output logic               fetch_valid_o,
    output logic [`DATA_W-1:0] fetch_data_o,
    mem_port_if.requester      mem
);

    localparam logic S_IDLE   = 1'b0;
    localparam logic S_REFILL = 1'b1;
    localparam logic [`OFFSET_W-1:0] LAST_WORD = `OFFSET_W'(`LINE_WORDS - 1);

    logic                  state;
    line_t                 data_array [`ICACHE_SETS];
    logic [`TAG_W-1:0]     tag_array  [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_q;

    cache_addr_u           look_a;
    cache_addr_u           req_a;
    cache_addr_u           bus_a;
    logic                  hit;
    logic [`OFFSET_W-1:0]  word_cnt;
    line_t                 line_buf;
    line_t                 fill_line;

    always_comb begin
        look_a.raw = fetch_addr_i;
    end

    assign hit = valid_q[look_a.fields.index] &&
                 (tag_array[look_a.fields.index] == look_a.fields.tag);

    // Refill walks the line from word 0 upward
    always_comb begin
        bus_a.fields.tag      = req_a.fields.tag;
        bus_a.fields.index    = req_a.fields.index;
        bus_a.fields.offset   = word_cnt;
        bus_a.fields.byte_sel = 2'b00;
    end

    always_comb begin
        fill_line           = line_buf;
        fill_line[word_cnt] = mem.rdata;
    end

    assign mem.addr  = bus_a.raw;
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;
    assign mem.wstrb = '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= S_IDLE;
            valid_q       <= '0;
            fetch_valid_o <= 1'b0;
            mem.req       <= 1'b0;
            word_cnt      <= '0;
        end else begin
            fetch_valid_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fetch_req_i) begin
                        if (hit) begin
                            fetch_valid_o <= 1'b1;
                        end else begin
                            state    <= S_REFILL;
                            mem.req  <= 1'b1;
                            word_cnt <= '0;
                        end
                    end
                end
                default: begin
                    if (mem.done) begin
                        word_cnt <= word_cnt + 1'b1;
                        // Last beat in, install the line and answer the fetch
                        if (word_cnt == LAST_WORD) begin
                            mem.req                       <= 1'b0;
                            valid_q[req_a.fields.index]   <= 1'b1;
                            fetch_valid_o                 <= 1'b1;
                            state                         <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && fetch_req_i) begin
            req_a        <= look_a;
            fetch_data_o <= data_array[look_a.fields.index][look_a.fields.offset];
        end
        if (state == S_REFILL && mem.done) begin
            line_buf <= fill_line;
            if (word_cnt == LAST_WORD) begin
                data_array[req_a.fields.index] <= fill_line;
                tag_array[req_a.fields.index]  <= req_a.fields.tag;
                fetch_data_o                   <= fill_line[req_a.fields.offset];
            end
        end
    end

endmodule

/* mem_arbiter.sv */
`include "core_defs.svh"

module mem_arbiter (
    input  logic          clk,
    input  logic          rst_n_i,
    mem_port_if.responder ifetch,
    mem_port_if.responder data,
    mem_port_if.requester bus
);

    localparam logic [1:0] OWN_NONE   = 2'd0;
    localparam logic [1:0] OWN_DATA   = 2'd1;
    localparam logic [1:0] OWN_IFETCH = 2'd2;

    logic [1:0] grant;
    logic [1:0] sel;

    // Free bus goes to the data port first
    always_comb begin
        sel = grant;
        if (grant == OWN_NONE) begin
            if (data.req) begin
                sel = OWN_DATA;
            end else if (ifetch.req) begin
                sel = OWN_IFETCH;
            end
        end
    end

    always_comb begin
        case (sel)
            OWN_DATA: begin
                bus.req   = data.req;
                bus.we    = data.we;
                bus.addr  = data.addr;
                bus.wdata = data.wdata;
                bus.wstrb = data.wstrb;
            end
            OWN_IFETCH: begin
                bus.req   = ifetch.req;
                bus.we    = ifetch.we;
                bus.addr  = ifetch.addr;
                bus.wdata = ifetch.wdata;
                bus.wstrb = ifetch.wstrb;
            end
            default: begin
                bus.req   = 1'b0;
                bus.we    = 1'b0;
                bus.addr  = '0;
                bus.wdata = '0;
                bus.wstrb = '0;
            end
        endcase
    end

    assign data.done    = bus.done && (grant == OWN_DATA);
    assign data.rdata   = (grant == OWN_DATA) ? bus.rdata : '0;
    assign ifetch.done  = bus.done && (grant == OWN_IFETCH);
    assign ifetch.rdata = (grant == OWN_IFETCH) ? bus.rdata : '0;

    // Released after every transfer, so refill beats can be interleaved
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant <= OWN_NONE;
        end else if (bus.done) begin
            grant <= OWN_NONE;
        end else if (grant == OWN_NONE) begin
            grant <= sel;
        end
    end

endmodule

/* mem_port_if.sv */
`include "core_defs.svh"

interface mem_port_if;

    logic               req;
    logic               we;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
    logic [`STRB_W-1:0] wstrb;
    logic               done;
    logic [`DATA_W-1:0] rdata;

    // Request fields stay stable from req until the done pulse
    modport requester (
        output req, we, addr, wdata, wstrb,
        input  done, rdata
    );

    modport responder (
        input  req, we, addr, wdata, wstrb,
        output done, rdata
    );

endinterface

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpu_mem_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_cpu_mem -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

/* tb_cpu_mem.sv */
`include "core_defs.svh"

module tb_cpu_mem import bus_pkg::*; ();

    localparam int          MAX_CYCLES = 4000;
    localparam logic [31:0] FILL_KEY   = 32'h5a5a_0000;

    logic               clk = 1'b0;
    logic               rst_n_i;
    logic               fetch_req_i;
    logic [`ADDR_W-1:0] fetch_addr_i;
    logic               fetch_valid_o;
    logic [`DATA_W-1:0] fetch_data_o;
    logic               data_req_i;
    logic               data_we_i;
    logic [`ADDR_W-1:0] data_addr_i;
    access_size_e       data_size_i;
    logic [`DATA_W-1:0] data_wdata_i;
    logic               data_valid_o;
    logic [`DATA_W-1:0] data_rdata_o;
    logic [`ADDR_W-1:0] m_axi_araddr_o;
    logic               m_axi_arvalid_o;
    logic               m_axi_arready_i = 1'b0;
    logic [`DATA_W-1:0] m_axi_rdata_i = '0;
    logic               m_axi_rvalid_i = 1'b0;
    logic               m_axi_rready_o;
    logic [`ADDR_W-1:0] m_axi_awaddr_o;
    logic               m_axi_awvalid_o;
    logic               m_axi_awready_i = 1'b0;
    logic [`DATA_W-1:0] m_axi_wdata_o;
    logic [`STRB_W-1:0] m_axi_wstrb_o;
    logic               m_axi_wvalid_o;
    logic               m_axi_wready_i = 1'b0;
    logic               m_axi_bvalid_i = 1'b0;
    logic               m_axi_bready_o;

    int          val_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;
    logic [31:0] exp_fetch = '0;
    logic [31:0] exp_data = '0;
    logic [31:0] exp_awaddr = '0;
    logic [3:0]  exp_wstrb = '0;
    logic [31:0] exp_ar [0:63];
    int          ar_head = 0;
    int          ar_tail = 0;
    logic        quiet = 1'b1;
    logic        hit_first = 1'b0;

    // Memory model state
    logic [31:0] mem_words [logic [31:0]];
    int          ar_dly = 0;
    int          aw_dly = 0;
    int          w_dly = 0;
    logic        r_pend = 1'b0;
    logic        aw_got = 1'b0;
    logic        w_got = 1'b0;
    logic [31:0] ar_addr_q = '0;
    logic [31:0] aw_addr_q = '0;
    logic [31:0] wdata_q = '0;
    logic [3:0]  wstrb_q = '0;

    cpu_mem_top DUT (.*);

    always #10 clk = ~clk;

    // Content of a word that was never written
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ FILL_KEY;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (mem_words.exists(base)) begin
            return mem_words[base];
        end
        return fill_word(base);
    endfunction

    function automatic void merge_write(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [3:0] strb);
        logic [31:0] word;
        int          i;
        word = model_word(addr);
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        mem_words[{addr[31:2], 2'b00}] = word;
    endfunction

    // AXI slave raises each ready or valid only while the other side waits
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (m_axi_rvalid_i) begin
                m_axi_rvalid_i = 1'b0;
            end
            if (m_axi_arready_i) begin
                m_axi_arready_i = 1'b0;
                m_axi_rdata_i   = model_word(ar_addr_q);
                r_pend          = 1'b1;
                ar_head         = ar_head + 1;
            end else if (m_axi_arvalid_o) begin
                if (ar_dly == 0) begin
                    m_axi_arready_i = 1'b1;
                    ar_addr_q       = m_axi_araddr_o;
                    ar_dly          = $urandom_range(3, 0);
                end else begin
                    ar_dly = ar_dly - 1;
                end
            end
            if (r_pend && m_axi_rready_o) begin
                m_axi_rvalid_i = 1'b1;
                r_pend         = 1'b0;
            end
            if (m_axi_bvalid_i) begin
                m_axi_bvalid_i = 1'b0;
            end
            if (m_axi_awready_i) begin
                m_axi_awready_i = 1'b0;
                aw_got          = 1'b1;
            end else if (m_axi_awvalid_o && !aw_got) begin
                if (aw_dly == 0) begin
                    m_axi_awready_i = 1'b1;
                    aw_addr_q       = m_axi_awaddr_o;
                    aw_dly          = $urandom_range(3, 0);
                end else begin
                    aw_dly = aw_dly - 1;
                end
            end
            if (m_axi_wready_i) begin
                m_axi_wready_i = 1'b0;
                w_got          = 1'b1;
            end else if (m_axi_wvalid_o && !w_got) begin
                if (w_dly == 0) begin
                    m_axi_wready_i = 1'b1;
                    wdata_q        = m_axi_wdata_o;
                    wstrb_q        = m_axi_wstrb_o;
                    w_dly          = $urandom_range(3, 0);
                end else begin
                    w_dly = w_dly - 1;
                end
            end
            if (aw_got && w_got && m_axi_bready_o) begin
                merge_write(aw_addr_q, wdata_q, wstrb_q);
                m_axi_bvalid_i = 1'b1;
                aw_got         = 1'b0;
                w_got          = 1'b0;
            end
        end
    end

    // Bus stays silent before the first request
    assert property (@(posedge clk) disable iff (!rst_n_i)
        quiet |-> !(m_axi_arvalid_o || m_axi_rready_o || m_axi_awvalid_o || m_axi_wvalid_o ||
                    m_axi_bready_o || fetch_valid_o || data_valid_o))
        else begin
            other_errs++;
            $display("Bus or valid output went high before any request");
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_valid_o |-> fetch_data_o == exp_fetch)
        else begin
            val_errs++;
            $display("ERR fetch_data_o got %h exp %h", fetch_data_o, exp_fetch);
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_valid_o |-> ar_head == ar_tail)
        else begin
            other_errs++;
            $display("Fetch finished with %0d read address handshakes still missing",
                     ar_tail - ar_head);
        end

    // Hit answers in the cycle after the request is seen
    assert property (@(posedge clk) disable iff (!rst_n_i)
        hit_first |=> fetch_valid_o)
        else begin
            other_errs++;
            $display("Cache hit did not answer one cycle after the request");
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (m_axi_arvalid_o && m_axi_arready_i) |-> ar_head < ar_tail)
        else begin
            other_errs++;
            $display("Read address handshake that no access asked for");
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (m_axi_arvalid_o && m_axi_arready_i && ar_head < ar_tail) |->
            m_axi_araddr_o == exp_ar[ar_head])
        else begin
            val_errs++;
            $display("ERR m_axi_araddr_o got %h exp %h", m_axi_araddr_o, exp_ar[ar_head]);
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        data_valid_o |-> data_rdata_o == exp_data)
        else begin
            val_errs++;
            $display("ERR data_rdata_o got %h exp %h", data_rdata_o, exp_data);
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (m_axi_wvalid_o && m_axi_wready_i) |-> m_axi_wstrb_o == exp_wstrb)
        else begin
            val_errs++;
            $display("ERR m_axi_wstrb_o got %h exp %h", m_axi_wstrb_o, exp_wstrb);
        end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (m_axi_awvalid_o && m_axi_awready_i) |-> m_axi_awaddr_o == exp_awaddr)
        else begin
            val_errs++;
            $display("ERR m_axi_awaddr_o got %h exp %h", m_axi_awaddr_o, exp_awaddr);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Run stopped after %0d cycles with accesses unfinished", MAX_CYCLES);
            $display("Errors: %0d value, %0d other", val_errs, other_errs + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic expect_ar(input logic [31:0] addr);
        exp_ar[ar_tail] = addr;
        ar_tail         = ar_tail + 1;
    endtask

    task automatic expect_refill(input logic [31:0] addr);
        int w;
        for (w = 0; w < 4; w++) begin
            expect_ar({addr[31:4], 4'h0} + 32'(w * 4));
        end
    endtask

    task automatic fetch_word(input logic [31:0] addr, input logic miss);
        exp_fetch = fill_word(addr);
        if (miss) begin
            expect_refill(addr);
        end
        hit_first    = !miss;
        quiet        = 1'b0;
        fetch_addr_i = addr;
        fetch_req_i  = 1'b1;
        @(negedge clk);
        hit_first = 1'b0;
        while (!fetch_valid_o) begin
            @(negedge clk);
        end
        fetch_req_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input access_size_e size, input logic [31:0] wdata,
                               input logic [31:0] exp_rd, input logic [3:0] strb);
        exp_data = exp_rd;
        if (we) begin
            exp_wstrb  = strb;
            exp_awaddr = {addr[31:2], 2'b00};
        end else begin
            expect_ar({addr[31:2], 2'b00});
        end
        quiet        = 1'b0;
        data_we_i    = we;
        data_addr_i  = addr;
        data_size_i  = size;
        data_wdata_i = wdata;
        data_req_i   = 1'b1;
        @(negedge clk);
        while (!data_valid_o) begin
            @(negedge clk);
        end
        data_req_i = 1'b0;
        @(negedge clk);
    endtask

    // Refill and data load start together and the load must win the bus first
    task automatic fetch_and_load(input logic [31:0] faddr, input logic [31:0] daddr);
        logic f_done;
        logic d_done;
        exp_fetch = fill_word(faddr);
        exp_data  = fill_word(daddr);
        expect_ar({daddr[31:2], 2'b00});
        expect_refill(faddr);
        f_done       = 1'b0;
        d_done       = 1'b0;
        fetch_addr_i = faddr;
        fetch_req_i  = 1'b1;
        data_we_i    = 1'b0;
        data_addr_i  = daddr;
        data_size_i  = SIZE_WORD;
        data_req_i   = 1'b1;
        while (!(f_done && d_done)) begin
            @(negedge clk);
            if (fetch_valid_o) begin
                f_done      = 1'b1;
                fetch_req_i = 1'b0;
            end
            if (data_valid_o) begin
                d_done     = 1'b1;
                data_req_i = 1'b0;
            end
        end
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] r_word;
        logic [31:0] b_word;
        logic [31:0] h_word;
        logic [31:0] e_word;
        logic [31:0] merged;
        void'($urandom(32'haa40_3726));
        rst_n_i      = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_size_i  = SIZE_WORD;
        data_wdata_i = '0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (6) @(negedge clk);

        fetch_word(32'h0000_0104, 1'b1);
        fetch_word(32'h0000_010c, 1'b0);
        fetch_word(32'h0000_0100, 1'b0);

        r_word = $urandom();
        data_access(1'b1, 32'h1000_0040, SIZE_WORD, r_word, 32'h0, 4'b1111);
        data_access(1'b0, 32'h1000_0040, SIZE_WORD, 32'h0, r_word, 4'b0000);

        // Byte at lane 1 and halfword at lanes 2 and 3 on top of the stored word
        b_word = $urandom();
        h_word = $urandom();
        data_access(1'b1, 32'h1000_0041, SIZE_BYTE, b_word, 32'h0, 4'b0010);
        data_access(1'b1, 32'h1000_0042, SIZE_HALF, h_word, 32'h0, 4'b1100);
        merged = {h_word[15:0], b_word[7:0], r_word[7:0]};
        data_access(1'b0, 32'h1000_0041, SIZE_BYTE, 32'h0, {24'h0, b_word[7:0]}, 4'b0000);
        data_access(1'b0, 32'h1000_0042, SIZE_HALF, 32'h0, {16'h0, h_word[15:0]}, 4'b0000);
        data_access(1'b0, 32'h1000_0043, SIZE_BYTE, 32'h0, {24'h0, h_word[15:8]}, 4'b0000);
        data_access(1'b0, 32'h1000_0040, SIZE_WORD, 32'h0, merged, 4'b0000);

        e_word = $urandom();
        data_access(1'b1, 32'h1000_0083, SIZE_BYTE, e_word, 32'h0, 4'b1000);
        merged        = fill_word(32'h1000_0080);
        merged[31:24] = e_word[7:0];
        data_access(1'b0, 32'h1000_0080, SIZE_WORD, 32'h0, merged, 4'b0000);
        data_access(1'b0, 32'h1000_0080, SIZE_HALF, 32'h0,
                    {16'h0, merged[15:0]}, 4'b0000);

        fetch_and_load(32'h0000_0238, 32'h1000_00c4);
        fetch_word(32'h0000_0230, 1'b0);

        repeat (4) @(negedge clk);
        $display("Errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
